/* design/cdr_pkg.sv */
package cdr_pkg;

    // adc and interpolator widths
    localparam int N_ADC = 8;
    localparam int N_TI  = 4;
    localparam int N_PI  = 8;

    // fractional bits carried by the loop estimators
    localparam int EST_SHIFT = 12;

    // gain fields are left-shift amounts
    localparam int GAIN_W = 4;

    // loop stays frozen this many cycles after reset release
    localparam int WARMUP_CYCLES = 32;

    // snapshot slots available in the consumer
    localparam int SNAP_CREDITS = 2;

    // detector accumulator, wide enough for the sum over all slices
    localparam int PD_SUM_W = N_ADC + 2 + $clog2(N_TI) + 1;

    // counter widths
    localparam int WARM_CNT_W = $clog2(WARMUP_CYCLES + 1);
    localparam int CREDIT_W   = $clog2(SNAP_CREDITS + 1);

    typedef logic signed [N_ADC-1:0] adc_sample_t;
    typedef adc_sample_t [N_TI-1:0] adc_word_t;

    typedef logic signed [N_ADC+1:0] phase_err_t;
    typedef logic signed [N_ADC+1+EST_SHIFT:0] est_t;
    typedef logic signed [PD_SUM_W-1:0] pd_sum_t;

    typedef logic [N_PI-1:0] pi_code_t;
    typedef logic [GAIN_W-1:0] gain_t;

    typedef logic [WARM_CNT_W-1:0] warm_cnt_t;
    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    // runtime loop configuration, held static while the loop runs
    typedef struct packed {
        gain_t      kp;
        gain_t      ki;
        gain_t      kr;
        phase_err_t pd_offset;
        logic       invert;
        logic       en_freq_est;
        logic       en_ramp_est;
        logic       en_ext_pi;
        pi_code_t   ext_pi_ctl;
    } cdr_cfg_t;

    // loop state as seen by the snapshot path
    typedef struct packed {
        pi_code_t phase_est;
        est_t     freq_est;
        est_t     ramp_est;
    } cdr_snap_t;

endpackage

/* design/mm_pd.sv */
`timescale 1ns/1ns

module mm_pd import cdr_pkg::*; (
    input  logic       clk,
    input  logic       ext_rstb,
    input  adc_word_t  adc_word_i,
    input  phase_err_t offset_i,
    output phase_err_t pd_err_o
);

    // last slice of the previous word, neighbour for slice 0
    adc_sample_t last_q;
    pd_sum_t     mm_sum;

    // x[k]*d[k-1] - x[k-1]*d[k] with d = sign decision (+1 or -1)
    function automatic pd_sum_t mm_term(adc_sample_t x_k, adc_sample_t x_n);
        pd_sum_t cur_ext;
        pd_sum_t nb_ext;
        pd_sum_t a;
        pd_sum_t b;
        cur_ext = pd_sum_t'(x_k);
        nb_ext  = pd_sum_t'(x_n);
        a = x_n[N_ADC-1] ? -cur_ext : cur_ext;
        b = x_k[N_ADC-1] ? -nb_ext : nb_ext;
        return a - b;
    endfunction

    always_comb begin
        adc_sample_t nb;
        mm_sum = '0;
        for (int i = 0; i < N_TI; i++) begin
            // slice 0 pairs with the tail of the last word
            nb = (i == 0) ? last_q : adc_word_i[i-1];
            mm_sum = mm_sum + mm_term(adc_word_i[i], nb);
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q   <= '0;
            pd_err_o <= '0;
        end else begin
            last_q   <= adc_word_i[N_TI-1];
            // result wraps into the error width
            pd_err_o <= phase_err_t'(mm_sum - pd_sum_t'(offset_i));
        end
    end

endmodule

/* design/cdr_loop_filter.sv */
`timescale 1ns/1ns

module cdr_loop_filter import cdr_pkg::*; (
    input  logic       clk,
    input  logic       ext_rstb,
    input  logic       ramp_clock_i,
    input  phase_err_t pd_err_i,
    input  cdr_cfg_t   cfg_i,
    output pi_code_t   pi_ctl_o,
    output logic       freq_lvl_cross_o,
    output cdr_snap_t  live_o
);

    warm_cnt_t  warm_cnt;
    logic       run;

    phase_err_t err_inv_q;
    phase_err_t err_q;

    logic       ramp_ff;
    logic       ramp_sync;

    est_t       err_ext;
    est_t       err_kp;
    est_t       err_ki;
    est_t       err_kr;

    est_t       phase_q;
    est_t       phase_d;
    est_t       freq_q;
    est_t       freq_d;
    est_t       freq_upd;
    est_t       prev_freq_upd_q;
    est_t       ramp_pls_q;
    est_t       ramp_pls_upd;
    est_t       ramp_pls_d;
    est_t       ramp_neg_q;
    est_t       ramp_neg_upd;
    est_t       ramp_neg_d;

    pi_code_t   loop_code;

    // warm-up counter saturates at WARMUP_CYCLES and the loop runs from then on
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            warm_cnt <= '0;
        end else if (!run) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    assign run = (warm_cnt == warm_cnt_t'(WARMUP_CYCLES));

    // gains applied as left shifts on the sign-extended error
    assign err_ext = est_t'(err_q);
    assign err_kp  = err_ext <<< cfg_i.kp;
    assign err_ki  = err_ext <<< cfg_i.ki;
    assign err_kr  = err_ext <<< cfg_i.kr;

    always_comb begin
        // each half accumulates only during its own raw ramp half
        ramp_pls_upd = ramp_pls_q + (ramp_clock_i ? err_kr : est_t'(0));
        ramp_neg_upd = ramp_neg_q + (ramp_clock_i ? est_t'(0) : err_kr);
        ramp_pls_d   = cfg_i.en_ramp_est ? ramp_pls_upd : est_t'(0);
        ramp_neg_d   = cfg_i.en_ramp_est ? ramp_neg_upd : est_t'(0);

        freq_upd = err_ki + (ramp_sync ? ramp_pls_q : -ramp_neg_q);
        freq_d   = freq_q + (cfg_i.en_freq_est ? freq_upd : est_t'(0));

        phase_d  = phase_q + err_kp + freq_q;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_inv_q        <= '0;
            err_q            <= '0;
            phase_q          <= '0;
            freq_q           <= '0;
            prev_freq_upd_q  <= '0;
            ramp_pls_q       <= '0;
            ramp_neg_q       <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            err_inv_q        <= cfg_i.invert ? -pd_err_i : pd_err_i;
            err_q            <= run ? err_inv_q : '0;
            phase_q          <= run ? phase_d : '0;
            freq_q           <= run ? freq_d : '0;
            prev_freq_upd_q  <= run ? freq_upd : '0;
            ramp_pls_q       <= run ? ramp_pls_d : '0;
            ramp_neg_q       <= run ? ramp_neg_d : '0;
            // flag a rise of the frequency update
            freq_lvl_cross_o <= run && (freq_upd > prev_freq_upd_q);
        end
    end

    // two-flop synchronizer for the slow ramp clock
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_ff   <= 1'b0;
            ramp_sync <= 1'b0;
        end else begin
            ramp_ff   <= ramp_clock_i;
            ramp_sync <= ramp_ff;
        end
    end

    assign loop_code = pi_code_t'(phase_q >>> EST_SHIFT);
    assign pi_ctl_o  = cfg_i.en_ext_pi ? cfg_i.ext_pi_ctl : loop_code;

    assign live_o.phase_est = loop_code;
    assign live_o.freq_est  = freq_upd;
    assign live_o.ramp_est  = ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;

    a_warm_bound: assert property (@(posedge clk) disable iff (!ext_rstb)
        warm_cnt <= warm_cnt_t'(WARMUP_CYCLES));

endmodule

/* design/cdr_snapshot.sv */
`timescale 1ns/1ns

module cdr_snapshot import cdr_pkg::*; (
    input  logic      clk,
    input  logic      ext_rstb,
    input  cdr_snap_t live_i,
    input  logic      snap_req_i,
    input  logic      snap_credit_i,
    output logic      snap_valid_o,
    output cdr_snap_t snap_data_o
);

    typedef enum logic [1:0] {
        WAIT,
        READY,
        SAMPLE
    } sampler_state_t;

    sampler_state_t state;
    logic           pending;
    credit_cnt_t    credit_q;

    // request edge detection with one capture per rising edge
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state <= WAIT;
        end else begin
            case (state)
                WAIT:    state <= snap_req_i ? WAIT : READY;
                // an edge while a snapshot is still pending is dropped
                READY:   if (snap_req_i) state <= pending ? WAIT : SAMPLE;
                SAMPLE:  state <= WAIT;
                default: state <= WAIT;
            endcase
        end
    end

    // live loop state taken in the SAMPLE state
    always_ff @(posedge clk) begin
        if (state == SAMPLE) begin
            snap_data_o <= live_i;
        end
    end

    assign snap_valid_o = pending && (credit_q != '0);

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pending  <= 1'b0;
            credit_q <= credit_cnt_t'(SNAP_CREDITS);
        end else begin
            if (state == SAMPLE) begin
                pending <= 1'b1;
            end else if (snap_valid_o) begin
                pending <= 1'b0;
            end
            // send and return in one cycle leave the count as is
            credit_q <= credit_q + credit_cnt_t'(snap_credit_i)
                        - credit_cnt_t'(snap_valid_o);
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!ext_rstb)
        credit_q <= credit_cnt_t'(SNAP_CREDITS));

    a_no_send_empty: assert property (@(posedge clk) disable iff (!ext_rstb)
        snap_valid_o |-> credit_q != '0);

endmodule

/* design/mm_cdr_top.sv */
`timescale 1ns/1ns

module mm_cdr_top import cdr_pkg::*; (
    input  logic      clk,
    input  logic      ext_rstb,
    input  adc_word_t adc_word_i,
    input  logic      ramp_clock_i,
    input  cdr_cfg_t  cfg_i,
    input  logic      snap_req_i,
    input  logic      snap_credit_i,
    output pi_code_t  pi_ctl_o,
    output logic      freq_lvl_cross_o,
    output logic      snap_valid_o,
    output cdr_snap_t snap_data_o
);

    phase_err_t pd_err;
    cdr_snap_t  live;

    mm_pd u_pd (
        .clk        (clk),
        .ext_rstb   (ext_rstb),
        .adc_word_i (adc_word_i),
        .offset_i   (cfg_i.pd_offset),
        .pd_err_o   (pd_err)
    );

    cdr_loop_filter u_loop (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .ramp_clock_i     (ramp_clock_i),
        .pd_err_i         (pd_err),
        .cfg_i            (cfg_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .live_o           (live)
    );

    // debug path, snapshots go out under credit flow control
    cdr_snapshot u_snap (
        .clk           (clk),
        .ext_rstb      (ext_rstb),
        .live_i        (live),
        .snap_req_i    (snap_req_i),
        .snap_credit_i (snap_credit_i),
        .snap_valid_o  (snap_valid_o),
        .snap_data_o   (snap_data_o)
    );

endmodule

/* test/tb_mm_cdr.sv */
`timescale 1ns/1ns

module tb_mm_cdr import cdr_pkg::*; ();

    localparam int ERR_W     = $bits(phase_err_t);
    localparam int EST_W     = $bits(est_t);
    localparam int RST_LEN   = 16;
    localparam int EXT_LEN   = 100;
    localparam int LOOP_LEN  = 300;
    localparam int RAMP_LEN  = 400;
    localparam int SNAP_LEN  = 600;
    localparam int DRAIN_LEN = 80;
    localparam int MAX_CYCLES = RST_LEN + WARMUP_CYCLES + EXT_LEN + 2 * LOOP_LEN
                                + RAMP_LEN + SNAP_LEN + DRAIN_LEN + 200;
    localparam int S_WAIT   = 0;
    localparam int S_READY  = 1;
    localparam int S_SAMPLE = 2;

    logic      clk;
    logic      ext_rstb;
    adc_word_t adc_word_i;
    logic      ramp_clock_i;
    cdr_cfg_t  cfg_i;
    logic      snap_req_i;
    logic      snap_credit_i;
    pi_code_t  pi_ctl_o;
    logic      freq_lvl_cross_o;
    logic      snap_valid_o;
    cdr_snap_t snap_data_o;

    // reference model state mirroring the loop registers
    longint    m_last, m_pd, m_err_inv, m_err;
    longint    m_phase, m_freq, m_prev_upd, m_rp, m_rn;
    int        m_warm, m_state, m_credit;
    logic      m_ramp_ff, m_ramp_sync, m_cross, m_pending;
    cdr_snap_t expect_q[$];
    // cycles each received snapshot is held before its credit goes back
    int        hold_q[$];

    logic      warm_chk, ext_rand_en, ramp_toggle_en, req_en;
    int        ramp_left, req_left, sent_cnt, cycle_cnt;

    mm_cdr_top UUT (.*);

    // two's complement wrap of v into w bits
    function automatic longint wrap_to(longint v, int w);
        longint span;
        longint r;
        span = longint'(1) << w;
        r = v & (span - 1);
        if (r >= (span >>> 1)) begin
            r = r - span;
        end
        return r;
    endfunction

    // mueller-muller sum x[k]*d[k-1] - x[k-1]*d[k] minus offset
    function automatic longint detector_out(adc_word_t w, longint prev, longint offset);
        longint sum;
        longint cur;
        longint nb;
        sum = 0;
        nb  = prev;
        for (int i = 0; i < N_TI; i++) begin
            cur = $signed(w[i]);
            sum = sum + ((nb < 0) ? -cur : cur) - ((cur < 0) ? -nb : nb);
            nb  = cur;
        end
        return wrap_to(sum - offset, ERR_W);
    endfunction

    function automatic longint expected_code();
        return (m_phase >>> EST_SHIFT) & ((longint'(1) << N_PI) - 1);
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic report_failure(string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic advance_model();
        logic      run;
        logic      valid;
        int        prev_state;
        longint    ekp, eki, ekr, upd, rp_u, rn_u;
        cdr_snap_t live;
        run  = (m_warm == WARMUP_CYCLES);
        ekp  = wrap_to(m_err << cfg_i.kp, EST_W);
        eki  = wrap_to(m_err << cfg_i.ki, EST_W);
        ekr  = wrap_to(m_err << cfg_i.kr, EST_W);
        // ramp halves follow the raw ramp clock and the frequency term the synced one
        rp_u = wrap_to(m_rp + (ramp_clock_i ? ekr : 0), EST_W);
        rn_u = wrap_to(m_rn + (ramp_clock_i ? 0 : ekr), EST_W);
        upd  = wrap_to(eki + (m_ramp_sync ? m_rp : -m_rn), EST_W);
        live.phase_est = pi_code_t'(expected_code());
        live.freq_est  = est_t'(upd);
        live.ramp_est  = est_t'(ramp_clock_i ? rp_u : rn_u);
        valid = m_pending && (m_credit != 0);
        prev_state = m_state;
        if (prev_state == S_SAMPLE) begin
            expect_q.push_back(live);
            m_state   = S_WAIT;
            m_pending = 1'b1;
        end else if (prev_state == S_WAIT && !snap_req_i) begin
            m_state = S_READY;
        end else if (prev_state == S_READY && snap_req_i) begin
            m_state = m_pending ? S_WAIT : S_SAMPLE;
        end
        if (prev_state != S_SAMPLE && valid) begin
            m_pending = 1'b0;
        end
        m_credit    = m_credit + int'(snap_credit_i) - int'(valid);
        m_cross     = run && (upd > m_prev_upd);
        m_prev_upd  = run ? upd : 0;
        m_phase     = run ? wrap_to(m_phase + ekp + m_freq, EST_W) : 0;
        m_freq      = run ? wrap_to(m_freq + (cfg_i.en_freq_est ? upd : 0), EST_W) : 0;
        m_rp        = (run && cfg_i.en_ramp_est) ? rp_u : 0;
        m_rn        = (run && cfg_i.en_ramp_est) ? rn_u : 0;
        m_err       = run ? m_err_inv : 0;
        m_err_inv   = cfg_i.invert ? wrap_to(-m_pd, ERR_W) : m_pd;
        m_pd        = detector_out(adc_word_i, m_last, cfg_i.pd_offset);
        m_last      = $signed(adc_word_i[N_TI-1]);
        m_ramp_sync = m_ramp_ff;
        m_ramp_ff   = ramp_clock_i;
        if (!run) begin
            m_warm++;
        end
    endtask

    always @(posedge clk) begin
        if (!ext_rstb) begin
            {m_last, m_pd, m_err_inv, m_err} = '0;
            {m_phase, m_freq, m_prev_upd, m_rp, m_rn} = '0;
            {m_ramp_ff, m_ramp_sync, m_cross, m_pending} = '0;
            m_warm   = 0;
            m_state  = S_WAIT;
            m_credit = SNAP_CREDITS;
        end else begin
            advance_model();
        end
    end

    task automatic pick_cfg(logic inv, logic ramp_on);
        cfg_i.kp          = gain_t'($urandom_range(7, 0));
        cfg_i.ki          = gain_t'($urandom_range(3, 0));
        cfg_i.kr          = gain_t'($urandom_range(3, 0));
        cfg_i.pd_offset   = phase_err_t'(int'($urandom_range(64, 0)) - 32);
        cfg_i.invert      = inv;
        cfg_i.en_freq_est = 1'b1;
        cfg_i.en_ramp_est = ramp_on;
        cfg_i.en_ext_pi   = 1'b0;
        cfg_i.ext_pi_ctl  = pi_code_t'($urandom);
    endtask

    task automatic compare_outputs();
        cdr_snap_t exp_snap;
        if (warm_chk) begin
            check_value("pi_ctl_o", pi_ctl_o, 0);
            check_value("freq_lvl_cross_o", freq_lvl_cross_o, 0);
        end
        check_value("pi_ctl_o", pi_ctl_o,
                    cfg_i.en_ext_pi ? longint'(cfg_i.ext_pi_ctl) : expected_code());
        check_value("freq_lvl_cross_o", freq_lvl_cross_o, m_cross);
        check_value("snap_valid_o", snap_valid_o, m_pending && (m_credit != 0));
        if (snap_valid_o) begin
            if (expect_q.size() == 0) begin
                report_failure("snapshot sent without an accepted request");
            end
            exp_snap = expect_q.pop_front();
            check_value("snap_data_o.phase_est", snap_data_o.phase_est, exp_snap.phase_est);
            check_value("snap_data_o.freq_est", snap_data_o.freq_est, exp_snap.freq_est);
            check_value("snap_data_o.ramp_est", snap_data_o.ramp_est, exp_snap.ramp_est);
            sent_cnt++;
            hold_q.push_back($urandom_range(20, 0));
        end
    endtask

    // check first and then drive the next inputs on the falling edge
    task automatic step_cycle();
        @(negedge clk);
        compare_outputs();
        snap_credit_i = 1'b0;
        if (hold_q.size() > 0 && hold_q[0] == 0) begin
            snap_credit_i = 1'b1;
            void'(hold_q.pop_front());
        end
        foreach (hold_q[i]) begin
            if (hold_q[i] > 0) begin
                hold_q[i]--;
            end
        end
        for (int i = 0; i < N_TI; i++) begin
            adc_word_i[i] = adc_sample_t'($urandom);
        end
        if (ext_rand_en) begin
            cfg_i.ext_pi_ctl = pi_code_t'($urandom);
        end
        if (ramp_toggle_en && ramp_left <= 1) begin
            ramp_clock_i = ~ramp_clock_i;
            ramp_left    = $urandom_range(30, 5);
        end else begin
            ramp_left--;
        end
        if (req_en && req_left <= 1) begin
            snap_req_i = ~snap_req_i;
            req_left   = snap_req_i ? $urandom_range(4, 1) : $urandom_range(15, 1);
        end else begin
            req_left--;
        end
    endtask

    task automatic run_cycles(int n);
        repeat (n) begin
            step_cycle();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            report_failure($sformatf("timeout: run went past %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        void'($urandom(41519));
        ext_rstb      = 1'b0;
        adc_word_i    = '0;
        ramp_clock_i  = 1'b0;
        cfg_i         = '0;
        snap_req_i    = 1'b0;
        snap_credit_i = 1'b0;
        {warm_chk, ext_rand_en, ramp_toggle_en, req_en} = '0;
        ramp_left     = 0;
        req_left      = 0;
        sent_cnt      = 0;
        repeat (RST_LEN) @(posedge clk);
        @(negedge clk);
        ext_rstb = 1'b1;
        pick_cfg(1'b0, 1'b0);
        warm_chk = 1'b1;
        run_cycles(WARMUP_CYCLES);
        warm_chk = 1'b0;
        // override on top of a running loop
        cfg_i.en_ext_pi = 1'b1;
        ext_rand_en     = 1'b1;
        run_cycles(EXT_LEN);
        ext_rand_en     = 1'b0;
        cfg_i.en_ext_pi = 1'b0;
        pick_cfg(1'b0, 1'b0);
        run_cycles(LOOP_LEN);
        pick_cfg(1'b1, 1'b0);
        run_cycles(LOOP_LEN);
        pick_cfg(1'b0, 1'b1);
        ramp_toggle_en = 1'b1;
        run_cycles(RAMP_LEN);
        // snapshot requests while the ramp keeps toggling
        req_en = 1'b1;
        run_cycles(SNAP_LEN);
        req_en     = 1'b0;
        snap_req_i = 1'b0;
        run_cycles(DRAIN_LEN);
        if (expect_q.size() != 0 || hold_q.size() != 0) begin
            report_failure("snapshots or credits still outstanding after the drain");
        end else if (sent_cnt == 0) begin
            report_failure("no snapshot was sent during the request phase");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* compile.f */
design/cdr_pkg.sv
design/mm_pd.sv
design/cdr_loop_filter.sv
design/cdr_snapshot.sv
design/mm_cdr_top.sv
test/tb_mm_cdr.sv

/* Bender.yml */
package:
  name: mm_cdr

sources:
  - design/cdr_pkg.sv
  - design/mm_pd.sv
  - design/cdr_loop_filter.sv
  - design/cdr_snapshot.sv
  - design/mm_cdr_top.sv
  - target: test
    files:
      - test/tb_mm_cdr.sv
